// File: rtl/dance_vga_pkg.sv
package dance_vga_pkg;

    // ------------------------------
    // 640x480 raster timing, 25 MHz
    // ------------------------------

    // full line and full frame
    localparam int HPIXELS = 800;
    localparam int VLINES  = 521;

    // sync pulse lengths, counted from 0
    localparam int HPULSE  = 96;
    localparam int VPULSE  = 2;

    // active window, start inclusive, end exclusive
    // 784 - 144 gives 640 columns
    localparam int HBP     = 144;
    localparam int HFP     = 784;
    // 511 - 31 gives 480 rows
    localparam int VBP     = 31;
    localparam int VFP     = 511;

    // ------------------------------
    // sprites and lanes
    // ------------------------------

    // square sprite edge
    localparam int ARROW_SIZE = 16;
    // address bits for one sprite row or column
    localparam int SPRITE_AW  = $clog2(ARROW_SIZE);
    localparam int NUM_ARROWS = 4;
    localparam int NUM_LANES  = 4;
    // filled shapes first, then the hollow ones
    localparam int NUM_SHAPES = 2 * NUM_LANES;
    localparam int SHAPE_BITS = $clog2(NUM_SHAPES);
    // one mask row per rom word
    localparam int ROM_DEPTH  = NUM_SHAPES * ARROW_SIZE;

    // target row bottom edge, exclusive
    localparam int TARGET_Y   = 25 + ARROW_SIZE;

    // one mask row of 16 bits per line of the file
    localparam string SPRITE_FILE = "rtl/arrow_sprites.hex";

    // ------------------------------
    // types
    // ------------------------------

    // screen or counter coordinate
    typedef logic [9:0] coord_t;
    // msb is the leftmost column
    typedef logic [ARROW_SIZE-1:0] sprite_row_t;
    // index of one of the eight masks
    typedef logic [SHAPE_BITS-1:0] shape_t;

    // x is the left edge, y the bottom edge (exclusive)
    typedef struct packed {
        coord_t x;
        coord_t y;
    } arrow_pos_t;

    // coordinates already relative to the active window
    typedef struct packed {
        coord_t h;
        coord_t v;
        logic   active;
    } raster_pos_t;

    typedef struct packed {
        logic [2:0] red;
        logic [2:0] green;
        logic [1:0] blue;
    } rgb_t;

    // left, down, up, right lane columns
    // lane k uses filled shape k and hollow shape k+4
    localparam coord_t LANE_X [NUM_LANES] = '{10'd100, 10'd200, 10'd300, 10'd400};

    // purple-ish rising arrows
    localparam rgb_t ARROW_COLOR  = '{red: 3'b100, green: 3'b000, blue: 2'b11};
    // red target outlines
    localparam rgb_t TARGET_COLOR = '{red: 3'b111, green: 3'b000, blue: 2'b00};

endpackage

// File: rtl/raster_timing.sv
module raster_timing (
    input  logic                       dclk,
    input  logic                       clr,
    output dance_vga_pkg::raster_pos_t pos,
    output logic                       hsync,
    output logic                       vsync
);

    import dance_vga_pkg::*;

    // free running position in the full frame
    coord_t hc;
    coord_t vc;

    // last pixel of a line, last line of a frame
    logic   h_wrap;
    logic   v_wrap;

    // active window flags
    logic   h_active;
    logic   v_active;

    // ------------------------------
    // horizontal and vertical counters
    // ------------------------------

    assign h_wrap = (hc == coord_t'(HPIXELS - 1));
    assign v_wrap = (vc == coord_t'(VLINES - 1));

    always_ff @(posedge dclk or posedge clr)
    begin
        if (clr)
        begin
            hc <= '0;
            vc <= '0;
        end
        else
        begin
            if (h_wrap)
            begin
                hc <= '0;
                // vc only moves at end of line
                if (v_wrap)
                    vc <= '0;
                else
                    vc <= vc + coord_t'(1);
            end
            else
            begin
                hc <= hc + coord_t'(1);
            end
        end
    end

    // ------------------------------
    // active window decode
    // ------------------------------

    // [HBP,HFP) x [VBP,VFP)
    assign h_active = (hc >= coord_t'(HBP)) && (hc < coord_t'(HFP));
    assign v_active = (vc >= coord_t'(VBP)) && (vc < coord_t'(VFP));

    // offsets wrap outside the window, but active is low there
    assign pos.h      = hc - coord_t'(HBP);
    assign pos.v      = vc - coord_t'(VBP);
    assign pos.active = h_active && v_active;

    // ------------------------------
    // sync outputs
    // ------------------------------

    // active low, registered to line up with the painted pixel
    // idle high while in reset
    always_ff @(posedge dclk or posedge clr)
    begin
        if (clr)
        begin
            hsync <= 1'b1;
            vsync <= 1'b1;
        end
        else
        begin
            hsync <= (hc >= coord_t'(HPULSE));
            vsync <= (vc >= coord_t'(VPULSE));
        end
    end

endmodule

// File: rtl/arrow_painter.sv
module arrow_painter (
    input  logic                       dclk,
    input  logic                       clr,
    input  dance_vga_pkg::raster_pos_t pos,
    input  dance_vga_pkg::arrow_pos_t  arrows [dance_vga_pkg::NUM_ARROWS],
    output dance_vga_pkg::rgb_t        pixel
);

    import dance_vga_pkg::*;

    // all eight masks, shape-major, top row first
    sprite_row_t sprite_rom [ROM_DEPTH];

    // one hit flag per rising arrow and per target
    logic [NUM_ARROWS-1:0] arrow_hit;
    logic [NUM_LANES-1:0]  target_hit;

    // colour before the output register
    rgb_t                  next_pixel;

    initial
    begin
        $readmemh(SPRITE_FILE, sprite_rom);
    end

    // ------------------------------
    // box and mask test
    // ------------------------------

    // box is [x, x+16) by [ybot-16, ybot)
    // ybot below 16 means hidden
    function automatic logic mask_bit(
        input shape_t shape,
        input coord_t h,
        input coord_t v,
        input coord_t x,
        input coord_t ybot
    );
        coord_t      top;
        coord_t      col;
        coord_t      row;
        logic        in_box;
        sprite_row_t line;
        begin
            top = ybot - coord_t'(ARROW_SIZE);
            // only valid once h >= x and v >= top
            col = h - x;
            row = v - top;
            in_box = (ybot >= coord_t'(ARROW_SIZE)) &&
                     (h >= x) && (col < coord_t'(ARROW_SIZE)) &&
                     (v >= top) && (v < ybot);
            line = sprite_rom[{shape, row[SPRITE_AW-1:0]}];
            // msb is column 0, so invert the column bits
            mask_bit = in_box && line[~col[SPRITE_AW-1:0]];
        end
    endfunction

    // ------------------------------
    // rising arrows
    // ------------------------------

    for (genvar i = 0; i < NUM_ARROWS; i++)
    begin : g_arrow
        shape_t shape;

        // lane decode from x
        // no matching lane falls back to shape 3
        always_comb
        begin
            shape = shape_t'(NUM_LANES - 1);
            for (int k = 0; k < NUM_LANES; k++)
            begin
                if (arrows[i].x == LANE_X[k])
                    shape = shape_t'(k);
            end
        end

        assign arrow_hit[i] = mask_bit(shape, pos.h, pos.v, arrows[i].x, arrows[i].y);
    end

    // ------------------------------
    // target row
    // ------------------------------

    // fixed lane columns, hollow masks sit after the filled ones
    for (genvar k = 0; k < NUM_LANES; k++)
    begin : g_target
        assign target_hit[k] = mask_bit(shape_t'(k + NUM_LANES), pos.h, pos.v,
                                        LANE_X[k], coord_t'(TARGET_Y));
    end

    // ------------------------------
    // colour priority
    // ------------------------------

    // arrow bit, then target bit, then black
    // blank outside the window
    always_comb
    begin
        next_pixel = '0;
        if (pos.active)
        begin
            if (|arrow_hit)
                next_pixel = ARROW_COLOR;
            else if (|target_hit)
                next_pixel = TARGET_COLOR;
        end
    end

    // one cycle behind pos, same as the sync registers
    always_ff @(posedge dclk or posedge clr)
    begin
        if (clr)
            pixel <= '0;
        else
            pixel <= next_pixel;
    end

endmodule

// File: rtl/dance_vga_top.sv
module dance_vga_top (
    input  logic                      dclk,
    input  logic                      clr,
    input  dance_vga_pkg::arrow_pos_t arrows [dance_vga_pkg::NUM_ARROWS],
    output logic                      hsync,
    output logic                      vsync,
    output dance_vga_pkg::rgb_t       pixel
);

    import dance_vga_pkg::*;

    // current scan position, combinational from the counters
    raster_pos_t pos;

    // ------------------------------
    // counters and sync
    // ------------------------------

    raster_timing u_timing (
        .dclk  (dclk),
        .clr   (clr),
        .pos   (pos),
        .hsync (hsync),
        .vsync (vsync)
    );

    // ------------------------------
    // sprite drawing
    // ------------------------------

    // arrows are held by the game logic for a whole frame
    arrow_painter u_painter (
        .dclk   (dclk),
        .clr    (clr),
        .pos    (pos),
        .arrows (arrows),
        .pixel  (pixel)
    );

endmodule

// File: testbench/dance_vga_chk.sv
module dance_vga_chk (
    input  logic                  dclk,
    input  logic                  clr,
    input  dance_vga_pkg::coord_t hc,
    input  dance_vga_pkg::coord_t vc,
    input  logic                  hsync,
    input  logic                  vsync
);

    import dance_vga_pkg::*;

    // failed assertions so far, read by the testbench top
    int fail_count = 0;

    // ------------------------------
    // counter ranges
    // ------------------------------

    a_hc_range : assert property (@(posedge dclk) disable iff (clr)
        hc < coord_t'(HPIXELS))
    else
    begin
        fail_count++;
        $error("horizontal counter left the line range");
    end

    a_vc_range : assert property (@(posedge dclk) disable iff (clr)
        vc < coord_t'(VLINES))
    else
    begin
        fail_count++;
        $error("vertical counter left the frame range");
    end

    // vc may only step at the last pixel of a line
    a_vc_step : assert property (@(posedge dclk) disable iff (clr)
        !$stable(vc) |-> ($past(hc) == coord_t'(HPIXELS - 1)))
    else
    begin
        fail_count++;
        $error("vertical counter moved in the middle of a line");
    end

    // ------------------------------
    // sync pulses
    // ------------------------------

    // sync lags the counter by one register
    a_hsync_low : assert property (@(posedge dclk) disable iff (clr)
        !hsync |-> ($past(hc) < coord_t'(HPULSE)))
    else
    begin
        fail_count++;
        $error("hsync low outside the pulse");
    end

    a_vsync_low : assert property (@(posedge dclk) disable iff (clr)
        !vsync |-> ($past(vc) < coord_t'(VPULSE)))
    else
    begin
        fail_count++;
        $error("vsync low outside the pulse");
    end

endmodule

bind raster_timing dance_vga_chk u_chk (
    .dclk  (dclk),
    .clr   (clr),
    .hc    (hc),
    .vc    (vc),
    .hsync (hsync),
    .vsync (vsync)
);

// File: testbench/pixel_checker.sv
module pixel_checker (
    input  logic                      dclk,
    input  logic                      clr,
    input  dance_vga_pkg::arrow_pos_t arrows [dance_vga_pkg::NUM_ARROWS],
    input  logic                      hsync,
    input  logic                      vsync,
    input  dance_vga_pkg::rgb_t       pixel,
    output int                        sync_errors,
    output int                        pixel_errors,
    output int                        arrow_count
);

    import dance_vga_pkg::*;

    // private copy of the masks
    sprite_row_t sprites [ROM_DEPTH];

    // model counter, value the dut holds now
    int          mh;
    int          mv;
    // value the outputs describe, one edge behind
    int          ph;
    int          pv;
    arrow_pos_t  pa [NUM_ARROWS];
    logic        have_prev;

    initial
    begin
        sync_errors  = 0;
        pixel_errors = 0;
        arrow_count  = 0;
        $readmemh(SPRITE_FILE, sprites);
    end

    // ------------------------------
    // reference model
    // ------------------------------

    // filled shape of the lane at this column, right arrow otherwise
    function automatic int lane_shape(input int x);
        int shape;
        begin
            shape = 3;
            for (int k = 0; k < NUM_LANES; k++)
            begin
                if (x == int'(LANE_X[k]))
                    shape = k;
            end
            return shape;
        end
    endfunction

    // bottom edge is exclusive, bottom below one sprite hides it
    function automatic logic sprite_bit(
        input int shape,
        input int h,
        input int v,
        input int left,
        input int bottom
    );
        int                              top;
        logic [SHAPE_BITS+SPRITE_AW-1:0] addr;
        logic [SPRITE_AW-1:0]            sel;
        begin
            top = bottom - ARROW_SIZE;
            if (bottom < ARROW_SIZE || h < left || h >= left + ARROW_SIZE ||
                v < top || v >= bottom)
                return 1'b0;
            addr = (SHAPE_BITS + SPRITE_AW)'(shape * ARROW_SIZE + v - top);
            // column 0 sits in bit 15
            sel = SPRITE_AW'(ARROW_SIZE - 1 - (h - left));
            return sprites[addr][sel];
        end
    endfunction

    // same reset and wrap rule as the counters
    always @(posedge dclk or posedge clr)
    begin
        if (clr)
        begin
            mh        <= 0;
            mv        <= 0;
            have_prev <= 1'b0;
        end
        else
        begin
            ph        <= mh;
            pv        <= mv;
            pa        <= arrows;
            have_prev <= 1'b1;
            if (mh == HPIXELS - 1)
            begin
                mh <= 0;
                mv <= (mv == VLINES - 1) ? 0 : mv + 1;
            end
            else
            begin
                mh <= mh + 1;
            end
        end
    end

    // ------------------------------
    // compare on the falling edge
    // ------------------------------

    always @(negedge dclk)
    begin : compare
        int   h;
        int   v;
        logic arrow_on;
        logic target_on;
        logic exp_hs;
        logic exp_vs;
        rgb_t exp_px;

        exp_hs = 1'b1;
        exp_vs = 1'b1;
        exp_px = '0;
        if (!clr && have_prev)
        begin
            exp_hs = (ph >= HPULSE);
            exp_vs = (pv >= VPULSE);
            if (ph >= HBP && ph < HFP && pv >= VBP && pv < VFP)
            begin
                h = ph - HBP;
                v = pv - VBP;
                arrow_on  = 1'b0;
                target_on = 1'b0;
                for (int i = 0; i < NUM_ARROWS; i++)
                begin
                    arrow_on |= sprite_bit(lane_shape(int'(pa[i].x)), h, v,
                                           int'(pa[i].x), int'(pa[i].y));
                end
                // hollow masks follow the filled ones
                for (int k = 0; k < NUM_LANES; k++)
                begin
                    target_on |= sprite_bit(k + NUM_LANES, h, v, int'(LANE_X[k]), TARGET_Y);
                end
                if (arrow_on)
                    exp_px = ARROW_COLOR;
                else if (target_on)
                    exp_px = TARGET_COLOR;
            end
        end

        if (hsync !== exp_hs)
        begin
            sync_errors++;
            $display("Mismatch at %0t: hsync expected %0b actual %0b", $time, exp_hs, hsync);
        end
        if (vsync !== exp_vs)
        begin
            sync_errors++;
            $display("Mismatch at %0t: vsync expected %0b actual %0b", $time, exp_vs, vsync);
        end
        if (pixel !== exp_px)
        begin
            pixel_errors++;
            $display("Mismatch at %0t: pixel expected %h actual %h", $time, exp_px, pixel);
        end
        if (pixel == ARROW_COLOR)
            arrow_count++;
    end

endmodule

// File: testbench/tb_dance_vga.sv
module tb_dance_vga;

    import dance_vga_pkg::*;

    logic       dclk;
    logic       clr;
    arrow_pos_t arrows [NUM_ARROWS];
    logic       hsync;
    logic       vsync;
    rgb_t       pixel;

    // counts from the checker
    int         sync_errors;
    int         pixel_errors;
    int         arrow_count;
    int         scene_errors;

    // scene table, four positions and an arrow-expected flag per row
    arrow_pos_t scene_arrows [6][NUM_ARROWS];
    logic       scene_expect [6];

    dance_vga_top u_dut (
        .dclk   (dclk),
        .clr    (clr),
        .arrows (arrows),
        .hsync  (hsync),
        .vsync  (vsync),
        .pixel  (pixel)
    );

    pixel_checker u_check (
        .dclk         (dclk),
        .clr          (clr),
        .arrows       (arrows),
        .hsync        (hsync),
        .vsync        (vsync),
        .pixel        (pixel),
        .sync_errors  (sync_errors),
        .pixel_errors (pixel_errors),
        .arrow_count  (arrow_count)
    );

    initial
    begin
        dclk = 1'b0;
        forever
        begin
            #20 dclk = ~dclk;
        end
    end

    // ------------------------------
    // helpers
    // ------------------------------

    function automatic arrow_pos_t place(input int x, input int y);
        arrow_pos_t p;
        begin
            p.x = coord_t'(x);
            p.y = coord_t'(y);
            return p;
        end
    endfunction

    task automatic load_row(input int row, input int x0, input int y0, input int x1,
                            input int y1, input int x2, input int y2, input int x3,
                            input int y3, input logic expect_arrow);
        begin
            scene_arrows[row][0] = place(x0, y0);
            scene_arrows[row][1] = place(x1, y1);
            scene_arrows[row][2] = place(x2, y2);
            scene_arrows[row][3] = place(x3, y3);
            scene_expect[row]    = expect_arrow;
        end
    endtask

    task automatic fill_scene();
        begin
            // targets only, every arrow hidden
            load_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 1'b0);
            // one arrow per lane column
            load_row(1, 100, 200, 200, 260, 300, 320, 400, 380, 1'b1);
            // off-lane column falls back to the right arrow
            load_row(2, 500, 150, 0, 0, 0, 0, 0, 0, 1'b1);
            // arrows on top of targets
            load_row(3, 100, 41, 300, 50, 200, 0, 400, 0, 1'b1);
            // arrows on top of each other
            load_row(4, 200, 300, 200, 308, 208, 300, 0, 0, 1'b1);
            // bottom edge above row 16 hides the arrow
            load_row(5, 100, 15, 200, 10, 300, 1, 400, 15, 1'b0);
        end
    endtask

    // arrows change only here, on a rising edge
    task automatic apply_row(input int row);
        begin
            for (int i = 0; i < NUM_ARROWS; i++)
            begin
                arrows[i] <= scene_arrows[row][i];
            end
        end
    endtask

    // frame start, bounded by two frames of cycles
    task automatic wait_vsync_fall(output logic found);
        logic last;
        begin
            found = 1'b0;
            last  = vsync;
            for (int n = 0; n < 2 * HPIXELS * VLINES && !found; n++)
            begin
                @(posedge dclk);
                if (last && !vsync)
                    found = 1'b1;
                last = vsync;
            end
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------

    initial
    begin
        logic found;
        logic aborted;
        int   start_count;
        int   frame_pixels;
        int   total;

        clr = 1'b1;
        for (int i = 0; i < NUM_ARROWS; i++)
        begin
            arrows[i] = '0;
        end
        scene_errors = 0;
        aborted      = 1'b0;
        fill_scene();

        repeat (2) @(posedge dclk);
        clr <= 1'b0;

        wait_vsync_fall(found);
        if (!found)
        begin
            $display("timeout: vsync never fell after reset");
            scene_errors++;
            aborted = 1'b1;
        end

        for (int row = 0; row < 6 && !aborted; row++)
        begin
            apply_row(row);
            start_count = arrow_count;
            // whole frame under the new positions
            wait_vsync_fall(found);
            if (!found)
            begin
                $display("timeout: vsync never fell during scene row %0d", row);
                scene_errors++;
                aborted = 1'b1;
            end
            else
            begin
                frame_pixels = arrow_count - start_count;
                if ((frame_pixels > 0) != scene_expect[row])
                begin
                    scene_errors++;
                    $display("Mismatch at %0t: arrow_seen row %0d expected %0b actual %0b",
                             $time, row, scene_expect[row], frame_pixels > 0);
                end
            end
        end

        total = sync_errors + pixel_errors + scene_errors + u_dut.u_timing.u_chk.fail_count;
        $display("error counts: sync %0d, pixel %0d, scene %0d, assertion %0d",
                 sync_errors, pixel_errors, scene_errors, u_dut.u_timing.u_chk.fail_count);
        if (total == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: dance_vga.f
rtl/dance_vga_pkg.sv
rtl/raster_timing.sv
rtl/arrow_painter.sv
rtl/dance_vga_top.sv
testbench/dance_vga_chk.sv
testbench/pixel_checker.sv
testbench/tb_dance_vga.sv

// File: Makefile
# Verilator build and run for the VGA raster generator

VERILATOR ?= verilator
TOP       ?= tb_dance_vga
FILELIST  ?= dance_vga.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "FAIL: run did not complete"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/arrow_sprites.hex
// arrow masks, one 16-bit row per line, top row first, bit 15 is the leftmost column
// shapes 0 to 3 filled left, down, up, right; shapes 4 to 7 hollow in the same order
// shape 0, filled left
0100
0300
0700
0F00
1F00
3FFF
7FFF
FFFF
FFFF
7FFF
3FFF
1F00
0F00
0700
0300
0100
// shape 1, filled down
07E0
07E0
07E0
07E0
07E0
07E0
07E0
07E0
FFFF
7FFE
3FFC
1FF8
0FF0
07E0
03C0
0180
// shape 2, filled up
0180
03C0
07E0
0FF0
1FF8
3FFC
7FFE
FFFF
07E0
07E0
07E0
07E0
07E0
07E0
07E0
07E0
// shape 3, filled right
0080
00C0
00E0
00F0
00F8
FFFC
FFFE
FFFF
FFFF
FFFE
FFFC
00F8
00F0
00E0
00C0
0080
// shape 4, hollow left
0100
0300
0500
0900
1100
21FF
4001
8001
8001
4001
21FF
1100
0900
0500
0300
0100
// shape 5, hollow down
07E0
0420
0420
0420
0420
0420
0420
0420
FC3F
4002
2004
1008
0810
0420
0240
0180
// shape 6, hollow up
0180
0240
0420
0810
1008
2004
4002
FC3F
0420
0420
0420
0420
0420
0420
0420
07E0
// shape 7, hollow right
0080
00C0
00A0
0090
0088
FF84
8002
8001
8001
8002
FF84
0088
0090
00A0
00C0
0080
